// ==== list.f ====
+incdir+logic
logic/video_pkg.sv
logic/status_decode.sv
logic/sync_shift.sv
logic/colour_expand.sv
logic/crop_control.sv
logic/video_frontend.sv
test/video_clock.sv
test/video_assertions.sv
test/video_tb.sv

// ==== test/video_tb.sv ====
// Testbench for video_frontend: raster and OSD stimulus, reference model and per-cycle compare
`timescale 1ns/1ps
`include "video_settings.svh"

module video_tb;
    import video_pkg::*;

    localparam int LINE_PX  = 40;   // Short synthetic raster
    localparam int FRAME_LN = 20;

    logic                      clk_sys;
    logic                      rst;
    logic [63:0]               status;
    logic                      pxl_cen;
    logic                      pxl2_cen;
    logic [`VIDEO_COLOR_W-1:0] game_r;
    logic [`VIDEO_COLOR_W-1:0] game_g;
    logic [`VIDEO_COLOR_W-1:0] game_b;
    sync_t                     game_sync;
    hdmi_mode_t                hdmi;
    rgb24_t                    video_rgb;
    sync_t                     video_sync;
    crop_t                     crop;

    // Reference model state
    logic [63:0] m_status;
    logic [15:0] m_hs_line;
    logic [15:0] m_vs_line;
    logic        m_strobe;
    logic        m_hs_dly_l;
    logic        m_lhbl1;
    logic        m_lvbl1;
    sync_t       exp_sync;
    rgb24_t      exp_rgb;
    crop_t       exp_crop;

    int    errors = 0;
    int    asrt_seen = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    line_cnt = 0;
    bit    compare_on = 0;
    string cur_test = "reset";

    video_clock u_clock (.clk_sys(clk_sys), .rst(rst));

    video_frontend i_dut (
        .clk_sys(clk_sys), .rst(rst), .status(status), .pxl_cen(pxl_cen),
        .pxl2_cen(pxl2_cen), .game_r(game_r), .game_g(game_g), .game_b(game_b),
        .game_sync(game_sync), .hdmi(hdmi), .video_rgb(video_rgb),
        .video_sync(video_sync), .crop(crop)
    );

    // 5-bit channel followed by its top 3 bits
    function automatic logic [7:0] expand5(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    function automatic crop_t crop_ref(input logic [63:0] st, input hdmi_mode_t h);
        crop_t c;
        int    v;
        v = st[`ST_VCOPT_LSB +: 4];
        c.ok = h.width == 1920 && h.height == 1080 && st[`ST_FX_LSB +: 3] == 0 &&
               st[`ST_SCALE_LSB +: 3] == 0 && !h.force_scan2x && !h.direct_video;
        if (v < 6)
            c.off = 5'(2 * v);
        else
            c.off = 5'(((2 * v - 24) % 32 + 32) % 32);  // Wraps to negative
        c.size = (c.ok && st[`ST_CROP_EN_BIT]) ? 12'd216 : 12'd0;
        return c;
    endfunction

    // Cycle model reading pre-edge inputs and its own state
    always @(posedge clk_sys) begin
        if (rst) begin
            m_status <= '0;
            m_hs_line <= '0;
            m_vs_line <= '0;
            m_strobe <= 1'b0;
            m_hs_dly_l <= 1'b0;
            m_lhbl1 <= 1'b0;
            m_lvbl1 <= 1'b0;
            exp_sync <= '0;
            exp_rgb <= '0;
            exp_crop <= '0;
        end else begin
            m_status <= status;
            exp_crop <= crop_ref(m_status, hdmi);
            m_strobe <= pxl2_cen & ~pxl_cen;
            if (m_strobe)
                m_hs_line <= {m_hs_line[14:0], game_sync.hs};
            m_hs_dly_l <= m_hs_line[m_status[`ST_HOFS_LSB +: 4]];
            if (m_hs_line[m_status[`ST_HOFS_LSB +: 4]] && !m_hs_dly_l)
                m_vs_line <= {m_vs_line[14:0], game_sync.vs};   // New line
            exp_sync.hs <= m_hs_line[m_status[`ST_HOFS_LSB +: 4]];
            exp_sync.vs <= m_vs_line[m_status[`ST_VOFS_LSB +: 4]];
            m_lhbl1 <= game_sync.lhbl;
            m_lvbl1 <= game_sync.lvbl;
            exp_sync.lhbl <= m_lhbl1;
            exp_sync.lvbl <= m_lvbl1;
            exp_rgb <= {expand5(game_r), expand5(game_g), expand5(game_b)};
        end
    end

    task automatic check_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (exp_v === act_v) else begin
            $display("MISMATCH %s %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
            errors++;
        end
    endtask

    // Compare on the falling edge where outputs are stable
    always @(negedge clk_sys) begin
        if (compare_on && !rst) begin
            check_val("sync", exp_sync, video_sync);
            check_val("rgb", exp_rgb, video_rgb);
            check_val("crop", exp_crop, crop);
        end
    end

    task automatic finish_test(input int err_before);
        int asrt_new;
        asrt_new = i_dut.u_assertions.fail_count - asrt_seen;
        assert (asrt_new == 0) else begin
            $display("Concurrent assertions failed %0d times during test %s",
                     asrt_new, cur_test);
            errors += asrt_new;
            asrt_seen += asrt_new;
        end
        tests_run++;
        if (errors != err_before)
            tests_failed++;
        $display("Test %s done, %0d errors", cur_test, errors - err_before);
    endtask

    task automatic set_status(input int h, input int v, input int fx, input bit en,
                              input int vc, input int sc);
        status <= '0;
        status[`ST_HOFS_LSB +: 4] <= 4'(h);
        status[`ST_VOFS_LSB +: 4] <= 4'(v);
        status[`ST_FX_LSB +: 3] <= 3'(fx);
        status[`ST_CROP_EN_BIT] <= en;
        status[`ST_VCOPT_LSB +: 4] <= 4'(vc);
        status[`ST_SCALE_LSB +: 3] <= 3'(sc);
    endtask

    // Four clocks per pixel with the strobe phase at the second pxl2_cen pulse
    task automatic run_lines(input int n);
        int fl;
        for (int l = 0; l < n; l++) begin
            fl = line_cnt % FRAME_LN;
            for (int px = 0; px < LINE_PX; px++) begin
                for (int ph = 0; ph < 4; ph++) begin
                    @(posedge clk_sys);
                    pxl_cen <= ph == 0;
                    pxl2_cen <= ph == 0 || ph == 2;
                    game_sync.hs <= px < 6;
                    game_sync.vs <= fl < 2;
                    game_sync.lhbl <= px < 32;
                    game_sync.lvbl <= fl < 17;
                end
            end
            line_cnt++;
        end
    endtask

    initial begin
        int    eb;
        int    t;
        int    v;
        crop_t want;
        void'($urandom(32'hec68_9be2));
        status = '0;
        pxl_cen = 1'b0;
        pxl2_cen = 1'b0;
        game_r = '0;
        game_g = '0;
        game_b = '0;
        game_sync = '0;
        hdmi = '0;

        // 1. Reset state
        eb = errors;
        t = 0;
        while (rst !== 1'b0) begin
            @(posedge clk_sys);
            t++;
            if (t > 100) begin
                $display("Timeout: reset was never released");
                $display("Simulation failed");
                $finish;
            end
        end
        compare_on = 1;
        @(negedge clk_sys);
        check_val("crop after reset", 0, crop);
        check_val("sync after reset", 0, video_sync);
        finish_test(eb);

        // 2. Colour expansion with random blanking
        cur_test = "colour";
        eb = errors;
        repeat (50) begin
            @(posedge clk_sys);
            game_r <= $urandom;
            game_g <= $urandom;
            game_b <= $urandom;
            game_sync.lhbl <= $urandom;
            game_sync.lvbl <= $urandom;
        end
        repeat (3) @(posedge clk_sys);
        finish_test(eb);

        // 3. Crop decision
        cur_test = "crop_decision";
        eb = errors;
        for (int i = 0; i < 40; i++) begin
            @(posedge clk_sys);
            set_status(0, 0, ($urandom % 2) ? 0 : $urandom, $urandom, $urandom,
                       ($urandom % 2) ? 0 : $urandom);
            if (i % 2 == 0) begin
                hdmi.width <= 12'd1920;
                hdmi.height <= 12'd1080;
            end else begin
                hdmi.width <= ($urandom % 4 == 0) ? 12'd1920 : 12'($urandom);
                hdmi.height <= ($urandom % 4 == 0) ? 12'd1080 : 12'($urandom);
            end
            hdmi.force_scan2x <= ($urandom % 4 == 0);
            hdmi.direct_video <= ($urandom % 4 == 0);
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            want = crop_ref(status, hdmi);
            check_val("crop ok", want.ok, crop.ok);
            check_val("crop size", want.size, crop.size);
        end
        finish_test(eb);

        // 4. Crop offset for every option
        cur_test = "crop_offset";
        eb = errors;
        @(posedge clk_sys);
        hdmi <= '0;
        for (int vc = 0; vc < 16; vc++) begin
            @(posedge clk_sys);
            set_status(0, 0, 0, 1'b1, vc, 0);
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            want = crop_ref(status, hdmi);
            check_val("crop off", want.off, crop.off);
        end
        finish_test(eb);

        // 5. Horizontal shift
        cur_test = "hshift";
        eb = errors;
        v = $urandom % 16;
        @(posedge clk_sys);
        set_status(v, 0, 0, 1'b0, 0, 0);
        run_lines(6);
        finish_test(eb);

        // 6. Vertical shift over three frames
        cur_test = "vshift";
        eb = errors;
        @(posedge clk_sys);
        set_status($urandom % 16, $urandom % 16, 0, 1'b0, 0, 0);
        run_lines(3 * FRAME_LN);
        finish_test(eb);

        compare_on = 0;
        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== test/video_assertions.sv ====
// Concurrent checks on the video front end outputs, bound to every video_frontend instance
`timescale 1ns/1ps
`include "video_settings.svh"

module video_assertions (
    input logic              clk_sys,
    input logic              rst,
    input video_pkg::crop_t  crop,
    input video_pkg::sync_t  video_sync
);
    import video_pkg::*;

    int fail_count = 0;     // Failed checks so far

    // Crop is either off or the fixed 1080p window
    crop_size_legal: assert property (@(posedge clk_sys)
        crop.size == 12'd0 || crop.size == 12'(`CROP_LINES))
        else begin
            $error("crop size %0d is neither 0 nor the crop height", crop.size);
            fail_count++;
        end

    crop_size_needs_ok: assert property (@(posedge clk_sys)
        crop.size != 12'd0 |-> crop.ok)
        else begin
            $error("crop size set while crop is not allowed");
            fail_count++;
        end

    // Reset clears crop permission and all sync outputs
    reset_clears_outputs: assert property (@(posedge clk_sys)
        rst |=> !crop.ok && video_sync == 4'b0000)
        else begin
            $error("outputs not cleared one cycle after reset");
            fail_count++;
        end

endmodule

bind video_frontend video_assertions u_assertions (
    .clk_sys    ( clk_sys    ),
    .rst        ( rst        ),
    .crop       ( crop       ),
    .video_sync ( video_sync )
);

// ==== test/video_clock.sv ====
// Testbench clock and reset source: 8 ns clk_sys, rst held high for the first 16 cycles
`timescale 1ns/1ps

module video_clock (
    output logic clk_sys,
    output logic rst
);
    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk_sys);
        rst <= 1'b0;    // Released on an edge like any other input
    end

endmodule

// ==== logic/video_frontend.sv ====
// Base video front end: OSD decode, sync shift, colour expansion and HDMI crop control
`timescale 1ns/1ps
`include "video_settings.svh"

module video_frontend (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic [63:0]               status,
    input  logic                      pxl_cen,
    input  logic                      pxl2_cen,
    input  logic [`VIDEO_COLOR_W-1:0] game_r,
    input  logic [`VIDEO_COLOR_W-1:0] game_g,
    input  logic [`VIDEO_COLOR_W-1:0] game_b,
    input  video_pkg::sync_t          game_sync,
    input  video_pkg::hdmi_mode_t     hdmi,
    output video_pkg::rgb24_t         video_rgb,
    output video_pkg::sync_t          video_sync,
    output video_pkg::crop_t          crop
);
    import video_pkg::*;

    video_cfg_t cfg;            // Shared by both branches
    sync_t      shifted_sync;

    status_decode u_status (
        .clk_sys    ( clk_sys       ),
        .rst        ( rst           ),
        .status     ( status        ),
        .cfg        ( cfg           )
    );

    // Video branch
    sync_shift u_sync_shift (
        .clk_sys    ( clk_sys       ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .pxl2_cen   ( pxl2_cen      ),
        .cfg        ( cfg           ),
        .sync_in    ( game_sync     ),
        .sync_out   ( shifted_sync  )
    );

    colour_expand #(
        .COLOR_W    ( `VIDEO_COLOR_W )
    ) u_colour (
        .clk_sys    ( clk_sys       ),
        .rst        ( rst           ),
        .game_r     ( game_r        ),
        .game_g     ( game_g        ),
        .game_b     ( game_b        ),
        .sync_in    ( shifted_sync  ),
        .rgb        ( video_rgb     ),
        .sync_out   ( video_sync    )
    );

    // Crop branch, status to crop in two cycles
    crop_control u_crop (
        .clk_sys    ( clk_sys       ),
        .rst        ( rst           ),
        .cfg        ( cfg           ),
        .hdmi       ( hdmi          ),
        .crop       ( crop          )
    );

endmodule

// ==== logic/crop_control.sv ====
// Works out whether the HDMI output may crop to 216 lines and where the crop window sits
`timescale 1ns/1ps
`include "video_settings.svh"

module crop_control (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  video_pkg::video_cfg_t cfg,
    input  video_pkg::hdmi_mode_t hdmi,
    output video_pkg::crop_t      crop
);
    import video_pkg::*;

    localparam logic [3:0] WRAP_FROM = 4'd6;   // First option with a negative offset

    crop_t      crop_next;
    logic       mode_1080p;
    logic       plain_video;
    logic [4:0] off_double;

    assign mode_1080p = hdmi.width == 12'(`CROP_HDMI_W) &&
                        hdmi.height == 12'(`CROP_HDMI_H);

    // Scanline FX, integer scaling and the scan doubler all
    // need the full picture height
    assign plain_video = cfg.fx == 3'd0 && cfg.crop_scale == 3'd0 &&
                         !hdmi.force_scan2x && !hdmi.direct_video;

    assign off_double = {cfg.vcopt, 1'b0};

    always_comb begin
        crop_next.ok = mode_1080p && plain_video;

        // Options 0..5 move down, 6..15 wrap to -12..+6 in 5-bit two's complement
        if (cfg.vcopt < WRAP_FROM) begin
            crop_next.off = off_double;
        end else begin
            crop_next.off = off_double - 5'(`CROP_WRAP);
        end

        crop_next.size = (crop_next.ok && cfg.crop_en) ? 12'(`CROP_LINES) : 12'd0;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            crop <= '0;
        end else begin
            crop <= crop_next;
        end
    end

endmodule

// ==== logic/colour_expand.sv ====
// Widens game colour to 8 bits per channel by bit repetition and registers it with the syncs
`timescale 1ns/1ps
`include "video_settings.svh"

module colour_expand #(
    parameter int COLOR_W = `VIDEO_COLOR_W      // 1 to 8
) (
    input  logic               clk_sys,
    input  logic               rst,
    input  logic [COLOR_W-1:0] game_r,
    input  logic [COLOR_W-1:0] game_g,
    input  logic [COLOR_W-1:0] game_b,
    input  video_pkg::sync_t   sync_in,
    output video_pkg::rgb24_t  rgb,
    output video_pkg::sync_t   sync_out
);
    import video_pkg::*;

    localparam int OUT_W = `VIDEO_OUT_W;

    rgb24_t rgb_next;

    // Repeat the channel from its MSB down until the output is full,
    // so full scale maps to full scale and black stays black
    function automatic logic [OUT_W-1:0] expand(input logic [COLOR_W-1:0] c);
        logic [OUT_W-1:0] w;
        for (int i = 0; i < OUT_W; i++) begin
            w[OUT_W-1-i] = c[COLOR_W-1-(i % COLOR_W)];
        end
        return w;
    endfunction

    always_comb begin
        rgb_next.r = expand(game_r);
        rgb_next.g = expand(game_g);
        rgb_next.b = expand(game_b);
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rgb      <= '0;
            sync_out <= '0;     // Blanking active
        end else begin
            rgb      <= rgb_next;
            sync_out <= sync_in;
        end
    end

endmodule

// ==== logic/sync_shift.sv ====
// Moves game hsync by whole pixels and vsync by whole lines to centre the picture on a CRT
`timescale 1ns/1ps
`include "video_settings.svh"

module sync_shift (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  pxl2_cen,
    input  video_pkg::video_cfg_t cfg,
    input  video_pkg::sync_t      sync_in,
    output video_pkg::sync_t      sync_out
);
    localparam int DEPTH = `VIDEO_SHIFT_DEPTH;

    logic             pxl1_cen;     // Pixel-centre strobe
    logic [DEPTH-1:0] hs_line;      // Entry 0 is the newest pixel
    logic [DEPTH-1:0] vs_line;      // Entry 0 is the newest line
    logic             hs_dly;
    logic             hs_dly_l;
    logic             hs_rise;
    logic             lhbl_q;
    logic             lvbl_q;

    // A pxl2_cen pulse without pxl_cen falls halfway through the pixel
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pxl1_cen <= 1'b0;
        end else begin
            pxl1_cen <= pxl2_cen & ~pxl_cen;
        end
    end

    // Pixel delay line for hsync
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hs_line <= '0;
        end else if (pxl1_cen) begin
            hs_line <= {hs_line[DEPTH-2:0], sync_in.hs};
        end
    end

    assign hs_dly  = hs_line[cfg.hoffset];
    assign hs_rise = hs_dly & ~hs_dly_l;    // One push per line

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hs_dly_l <= 1'b0;
        end else begin
            hs_dly_l <= hs_dly;
        end
    end

    // Line delay line for vsync, stepped by the already shifted hsync
    // so both syncs stay consistent when hoffset changes
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vs_line <= '0;
        end else if (hs_rise) begin
            vs_line <= {vs_line[DEPTH-2:0], sync_in.vs};
        end
    end

    // Blanking is not moved, only aligned with the register stage
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            lhbl_q <= 1'b0;
            lvbl_q <= 1'b0;
        end else begin
            lhbl_q <= sync_in.lhbl;
            lvbl_q <= sync_in.lvbl;
        end
    end

    always_comb begin
        sync_out.hs   = hs_dly;
        sync_out.vs   = vs_line[cfg.voffset];
        sync_out.lhbl = lhbl_q;
        sync_out.lvbl = lvbl_q;
    end

endmodule

// ==== logic/status_decode.sv ====
// Registers the video fields of the OSD status word for the sync and crop stages
`timescale 1ns/1ps
`include "video_settings.svh"

module status_decode (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic [63:0]           status,
    output video_pkg::video_cfg_t cfg
);
    import video_pkg::*;

    video_cfg_t cfg_next;

    // Pick each field at its fixed OSD position
    always_comb begin
        cfg_next.hoffset    = status[`ST_HOFS_LSB +: `VIDEO_OFS_W];
        cfg_next.voffset    = status[`ST_VOFS_LSB +: `VIDEO_OFS_W];
        cfg_next.fx         = status[`ST_FX_LSB +: 3];        // Scanlines
        cfg_next.crop_en    = status[`ST_CROP_EN_BIT];
        cfg_next.vcopt      = status[`ST_VCOPT_LSB +: 4];
        cfg_next.crop_scale = status[`ST_SCALE_LSB +: 3];
    end

    // The OSD word comes from another clock domain in the full core.
    // One register stage here keeps the downstream logic short
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cfg <= '0;
        end else begin
            cfg <= cfg_next;
        end
    end

endmodule

// ==== logic/video_pkg.sv ====
// Packed struct types passed between the video front end stages
`include "video_settings.svh"

package video_pkg;

    // Video fields decoded from the OSD status word
    typedef struct packed {
        logic [`VIDEO_OFS_W-1:0] hoffset;     // Pixels to move hsync
        logic [`VIDEO_OFS_W-1:0] voffset;     // Lines to move vsync
        logic [2:0]              fx;          // Scanline effect, 0 = none
        logic                    crop_en;     // User asked for crop
        logic [3:0]              vcopt;       // Crop position option
        logic [2:0]              crop_scale;
    } video_cfg_t;

    // Raster timing, blanking active low
    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } sync_t;

    typedef struct packed {
        logic [`VIDEO_OUT_W-1:0] r;
        logic [`VIDEO_OUT_W-1:0] g;
        logic [`VIDEO_OUT_W-1:0] b;
    } rgb24_t;

    // Vertical crop settings for the HDMI scaler
    typedef struct packed {
        logic        ok;          // Current video mode tolerates crop
        logic [4:0]  off;         // Signed, -16 to +15
        logic [11:0] size;        // Lines kept, 0 means no crop
    } crop_t;

    // HDMI output mode as reported by the platform
    typedef struct packed {
        logic [11:0] width;
        logic [11:0] height;
        logic        force_scan2x;
        logic        direct_video;
    } hdmi_mode_t;

endpackage

// ==== logic/video_settings.svh ====
// Shared widths, OSD status bit positions and HDMI crop constants, included by the video stages
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Channel widths
`define VIDEO_COLOR_W       5       // Default game colour width
`define VIDEO_OUT_W         8       // Output channel width

// Sync offset control
`define VIDEO_OFS_W         4
`define VIDEO_SHIFT_DEPTH   16      // Entries in each sync delay line

// Field positions inside the 64-bit OSD status word
`define ST_FX_LSB           3       // Scanline FX, 3 bits
`define ST_HOFS_LSB         16
`define ST_VOFS_LSB         20
`define ST_CROP_EN_BIT      24
`define ST_VCOPT_LSB        25      // Crop option, 4 bits
`define ST_SCALE_LSB        29      // Crop scale, 3 bits

// Only a 1080p HDMI mode permits the 216-line crop
`define CROP_HDMI_W         1920
`define CROP_HDMI_H         1080
`define CROP_LINES          216

// Options from 6 upward wrap to negative offsets
`define CROP_WRAP           24

`endif
